// File: design/axil_ram_writer.sv
//========================================
// AXI4-Lite write master, one transaction
// in flight, full-word strobes only
// wr_error is sticky until reset
//========================================
`timescale 1ns/1ns
`default_nettype none

module axil_ram_writer (
	input  wire                              clk_1x,
	input  wire                              rst_n,
	input  wire                              rd_valid,
	input  wire mem_pkg::ram_wr_t            rd_data,
	input  wire                              awready,
	input  wire                              wready,
	input  wire                              bvalid,
	input  wire  [mem_pkg::resp_w-1:0]       bresp,
	output logic                             rd_ready,
	output logic                             awvalid,
	output logic [mem_pkg::mem_addr_w-1:0]   awaddr,
	output logic                             wvalid,
	output logic [mem_pkg::mem_data_w-1:0]   wdata,
	output logic [mem_pkg::strb_w-1:0]       wstrb,
	output logic                             bready,
	output logic                             wr_error
);

	typedef enum logic [1:0] {
		st_idle,
		st_addr_data,
		st_resp
	} state_t;

	state_t state;
	logic   aw_pending;
	logic   w_pending;

	// Channels still waiting after this cycle
	assign aw_pending = awvalid && !awready;
	assign w_pending  = wvalid && !wready;

	// Pop only while idle
	assign rd_ready = (state == st_idle);
	assign wstrb    = '1;

	always_ff @(posedge clk_1x) begin
		if (state == st_idle && rd_valid) begin
			awaddr <= rd_data.addr;
			wdata  <= rd_data.data;
		end
	end

	//========================================
	// Transaction FSM
	//========================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			state    <= st_idle;
			awvalid  <= 1'b0;
			wvalid   <= 1'b0;
			bready   <= 1'b0;
			wr_error <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (rd_valid) begin
						awvalid <= 1'b1;
						wvalid  <= 1'b1;
						state   <= st_addr_data;
					end
				end
				st_addr_data: begin
					// AW and W may be accepted in different cycles
					awvalid <= aw_pending;
					wvalid  <= w_pending;
					if (!aw_pending && !w_pending) begin
						bready <= 1'b1;
						state  <= st_resp;
					end
				end
				st_resp: begin
					if (bvalid) begin
						bready <= 1'b0;
						state  <= st_idle;
						if (bresp != mem_pkg::resp_okay) begin
							wr_error <= 1'b1;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/dl_pkg.sv
//========================================
// Download constants for the ioctl path
// Region bases are byte offsets added to the
// address of the lower 16-bit word
//========================================
`default_nettype none

package dl_pkg;

	//========================================
	// ioctl bus widths
	//========================================
	localparam int ioctl_addr_w = 27;
	localparam int ioctl_data_w = 16;

	// Download index values sent by the host
	localparam logic [7:0] idx_bios = 8'd0;
	localparam logic [7:0] idx_exe  = 8'd1;
	localparam logic [7:0] idx_code = 8'd255;

	// Region bases in main memory
	localparam logic [ioctl_addr_w-1:0] bios_base = 27'h020_0000;
	localparam logic [ioctl_addr_w-1:0] exe_base  = 27'h040_0000;

	//========================================
	// Cheat code word
	//========================================
	// Values arrive big endian, the loader
	// is expected to have arranged them
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

// File: design/ioctl_unpacker.sv
//========================================
// Host expects words at ascending even addresses
// and ioctl_wr only while ioctl_wait is low
// Pushes are not gated by the full flags
//========================================
`timescale 1ns/1ns
`default_nettype none

module ioctl_unpacker (
	input  wire                               clk_1x,
	input  wire                               rst_n,
	input  wire                               ioctl_download,
	input  wire  [7:0]                        ioctl_index,
	input  wire  [dl_pkg::ioctl_addr_w-1:0]   ioctl_addr,
	input  wire  [dl_pkg::ioctl_data_w-1:0]   ioctl_dout,
	input  wire                               ioctl_wr,
	input  wire                               ram_full,
	input  wire                               code_full,
	output logic                              ioctl_wait,
	output logic                              ram_push,
	output mem_pkg::ram_wr_t                  ram_item,
	output logic                              code_push,
	output dl_pkg::cheat_code_t               code_item,
	output logic                              cheat_clear,
	output logic                              exe_done
);

	logic is_bios;
	logic is_exe;
	logic is_code;
	logic is_mem;

	// Lower half of the pending memory word
	logic [mem_pkg::mem_addr_w-1:0] lo_addr;
	logic [dl_pkg::ioctl_data_w-1:0] lo_data;

	// Partial cheat code
	logic [31:0] flags_q;
	logic [31:0] addr_q;
	logic [31:0] compare_q;
	logic [15:0] replace_lo_q;

	logic code_dl_q;
	logic exe_dl_q;

	//========================================
	// Download kind
	//========================================
	assign is_bios = ioctl_download && (ioctl_index == dl_pkg::idx_bios);
	assign is_exe  = ioctl_download && (ioctl_index == dl_pkg::idx_exe);
	assign is_code = ioctl_download && (ioctl_index == dl_pkg::idx_code);
	assign is_mem  = is_bios || is_exe;

	//========================================
	// Memory words
	//========================================
	// Upper half goes straight into the push
	assign ram_push = is_mem && ioctl_wr && ioctl_addr[1];

	always_comb begin
		ram_item.addr = lo_addr;
		ram_item.data = {ioctl_dout, lo_data};
	end

	always_ff @(posedge clk_1x) begin
		if (is_mem && ioctl_wr && !ioctl_addr[1]) begin
			lo_data <= ioctl_dout;
			lo_addr <= ioctl_addr + (is_exe ? dl_pkg::exe_base : dl_pkg::bios_base);
		end
	end

	//========================================
	// Cheat codes
	//========================================
	// Offset 14 completes the code
	assign code_push = is_code && ioctl_wr && (ioctl_addr[3:0] == 4'd14);

	always_comb begin
		code_item.flags   = flags_q;
		code_item.addr    = addr_q;
		code_item.compare = compare_q;
		code_item.replace = {ioctl_dout, replace_lo_q};
	end

	// Bottom word first, then top word, per field
	always_ff @(posedge clk_1x) begin
		if (is_code && ioctl_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  flags_q[15:0]    <= ioctl_dout;
				4'd2:  flags_q[31:16]   <= ioctl_dout;
				4'd4:  addr_q[15:0]     <= ioctl_dout;
				4'd6:  addr_q[31:16]    <= ioctl_dout;
				4'd8:  compare_q[15:0]  <= ioctl_dout;
				4'd10: compare_q[31:16] <= ioctl_dout;
				4'd12: replace_lo_q     <= ioctl_dout;
				default: ;
			endcase
		end
	end

	//========================================
	// Pulses and host back-pressure
	//========================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			code_dl_q   <= 1'b0;
			exe_dl_q    <= 1'b0;
			cheat_clear <= 1'b0;
			exe_done    <= 1'b0;
			ioctl_wait  <= 1'b0;
		end else begin
			code_dl_q   <= is_code;
			exe_dl_q    <= is_exe;
			// Start of a code download
			cheat_clear <= is_code && !code_dl_q;
			// End of an executable download
			exe_done    <= exe_dl_q && !is_exe;
			ioctl_wait  <= ram_full || code_full;
		end
	end

endmodule

`default_nettype wire

// File: design/loader_top.sv
//========================================
// Download path, ioctl in, AXI4-Lite writes
// and cheat codes out
// FIFO depths are set here and passed down
//========================================
`timescale 1ns/1ns
`default_nettype none

module loader_top #(
	parameter int RAM_FIFO_DEPTH  = 4,
	parameter int CODE_FIFO_DEPTH = 2
) (
	input  wire                              clk_1x,
	input  wire                              rst_n,
	// Host download
	input  wire                              ioctl_download,
	input  wire  [7:0]                       ioctl_index,
	input  wire  [dl_pkg::ioctl_addr_w-1:0]  ioctl_addr,
	input  wire  [dl_pkg::ioctl_data_w-1:0]  ioctl_dout,
	input  wire                              ioctl_wr,
	output wire                              ioctl_wait,
	// AXI4-Lite write channels
	output wire                              awvalid,
	input  wire                              awready,
	output wire  [mem_pkg::mem_addr_w-1:0]   awaddr,
	output wire                              wvalid,
	input  wire                              wready,
	output wire  [mem_pkg::mem_data_w-1:0]   wdata,
	output wire  [mem_pkg::strb_w-1:0]       wstrb,
	input  wire                              bvalid,
	output wire                              bready,
	input  wire  [mem_pkg::resp_w-1:0]       bresp,
	// Cheat codes
	output wire                              cheat_valid,
	output wire dl_pkg::cheat_code_t         cheat_code,
	input  wire                              cheat_ready,
	output wire                              cheat_clear,
	output wire                              exe_done,
	output wire                              wr_error
);

	wire                      ram_push;
	wire mem_pkg::ram_wr_t    ram_item;
	wire                      ram_full;
	wire                      ram_valid;
	wire mem_pkg::ram_wr_t    ram_rd_data;
	wire                      ram_ready;
	wire                      code_push;
	wire dl_pkg::cheat_code_t code_item;
	wire                      code_full;

	//========================================
	// Producer
	//========================================
	ioctl_unpacker i_unpacker (
		.clk_1x         (clk_1x),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.ram_full       (ram_full),
		.code_full      (code_full),
		.ioctl_wait     (ioctl_wait),
		.ram_push       (ram_push),
		.ram_item       (ram_item),
		.code_push      (code_push),
		.code_item      (code_item),
		.cheat_clear    (cheat_clear),
		.exe_done       (exe_done)
	);

	//========================================
	// Buffers
	//========================================
	sync_fifo #(
		.DEPTH     (RAM_FIFO_DEPTH),
		.payload_t (mem_pkg::ram_wr_t)
	) i_ram_fifo (
		.clk_1x   (clk_1x),
		.rst_n    (rst_n),
		.wr_en    (ram_push),
		.wr_data  (ram_item),
		.rd_ready (ram_ready),
		.full     (ram_full),
		.rd_valid (ram_valid),
		.rd_data  (ram_rd_data)
	);

	// Read side faces the cheat engine directly
	sync_fifo #(
		.DEPTH     (CODE_FIFO_DEPTH),
		.payload_t (dl_pkg::cheat_code_t)
	) i_code_fifo (
		.clk_1x   (clk_1x),
		.rst_n    (rst_n),
		.wr_en    (code_push),
		.wr_data  (code_item),
		.rd_ready (cheat_ready),
		.full     (code_full),
		.rd_valid (cheat_valid),
		.rd_data  (cheat_code)
	);

	//========================================
	// Memory writer
	//========================================
	axil_ram_writer i_writer (
		.clk_1x   (clk_1x),
		.rst_n    (rst_n),
		.rd_valid (ram_valid),
		.rd_data  (ram_rd_data),
		.awready  (awready),
		.wready   (wready),
		.bvalid   (bvalid),
		.bresp    (bresp),
		.rd_ready (ram_ready),
		.awvalid  (awvalid),
		.awaddr   (awaddr),
		.wvalid   (wvalid),
		.wdata    (wdata),
		.wstrb    (wstrb),
		.bready   (bready),
		.wr_error (wr_error)
	);

endmodule

`default_nettype wire

// File: design/mem_pkg.sv
//========================================
// Main memory write types and AXI4-Lite
// constants, write channels only
//========================================
`default_nettype none

package mem_pkg;

	// Memory side widths
	localparam int mem_addr_w = 27;
	localparam int mem_data_w = 32;

	// AXI4-Lite widths
	localparam int strb_w = mem_data_w / 8;
	localparam int resp_w = 2;

	localparam logic [resp_w-1:0] resp_okay = 2'b00;

	// One 32-bit write to main memory
	typedef struct packed {
		logic [mem_addr_w-1:0] addr;
		logic [mem_data_w-1:0] data;
	} ram_wr_t;

endpackage

`default_nettype wire

// File: design/sync_fifo.sv
//========================================
// Holds DEPTH+1 items, full rises at DEPTH
// The spare slot absorbs a push that lands
// before the registered wait reaches the host
//========================================
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
	parameter int  DEPTH     = 4,
	parameter type payload_t = logic [7:0]
) (
	input  wire           clk_1x,
	input  wire           rst_n,
	input  wire           wr_en,
	input  wire payload_t wr_data,
	input  wire           rd_ready,
	output logic          full,
	output logic          rd_valid,
	output payload_t      rd_data
);

	localparam int slots = DEPTH + 1;
	localparam int ptr_w = (slots > 1) ? $clog2(slots) : 1;
	localparam int cnt_w = $clog2(slots + 1);

	payload_t         mem [slots];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             do_wr;
	logic             do_rd;

	assign do_rd = rd_ready && (count != '0);
	assign do_wr = wr_en && (count != cnt_w'(slots));

	assign full     = (count >= cnt_w'(DEPTH));
	assign rd_valid = (count != '0);
	assign rd_data  = mem[rd_ptr];

	always_ff @(posedge clk_1x) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == ptr_w'(slots - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == ptr_w'(slots - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the loader testbench with Verilator, run it, then search the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_loader -f sources.f -o sim_loader
./obj_dir/sim_loader +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi

// File: sources.f
design/dl_pkg.sv
design/mem_pkg.sv
design/ioctl_unpacker.sv
design/sync_fifo.sv
design/axil_ram_writer.sv
design/loader_top.sv
tb/tb_clk_gen.sv
tb/loader_chk.sv
tb/tb_loader.sv

// File: tb/loader_chk.sv
//========================================
// AXI hold, reset state and pulse width
// checks, bound into every loader_top
//========================================
`timescale 1ns/1ns
`default_nettype none

module loader_chk (
	input wire        clk_1x,
	input wire        rst_n,
	input wire        awvalid,
	input wire        awready,
	input wire [26:0] awaddr,
	input wire        wvalid,
	input wire        wready,
	input wire [31:0] wdata,
	input wire        bready,
	input wire        ioctl_wait,
	input wire        cheat_clear,
	input wire        cheat_valid,
	input wire        exe_done,
	input wire        wr_error
);

	int chk_errors = 0;

	// Payload held until the channel is accepted
	aw_hold: assert property (@(posedge clk_1x) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin
			chk_errors++;
			$error("AW channel dropped or changed before awready");
		end

	w_hold: assert property (@(posedge clk_1x) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else begin
			chk_errors++;
			$error("W channel dropped or changed before wready");
		end

	reset_quiet: assert property (@(posedge clk_1x) $rose(rst_n) |->
		!(awvalid || wvalid || bready || ioctl_wait || cheat_clear ||
		cheat_valid || exe_done || wr_error))
		else begin
			chk_errors++;
			$error("control output high when reset was released");
		end

	//========================================
	// Single-cycle pulses
	//========================================
	clear_single: assert property (@(posedge clk_1x) disable iff (!rst_n)
		cheat_clear |=> !cheat_clear)
		else begin
			chk_errors++;
			$error("cheat_clear lasted two cycles");
		end

	exe_single: assert property (@(posedge clk_1x) disable iff (!rst_n)
		exe_done |=> !exe_done)
		else begin
			chk_errors++;
			$error("exe_done lasted two cycles");
		end

endmodule

bind loader_top loader_chk i_chk (
	.clk_1x      (clk_1x),
	.rst_n       (rst_n),
	.awvalid     (awvalid),
	.awready     (awready),
	.awaddr      (awaddr),
	.wvalid      (wvalid),
	.wready      (wready),
	.wdata       (wdata),
	.bready      (bready),
	.ioctl_wait  (ioctl_wait),
	.cheat_clear (cheat_clear),
	.cheat_valid (cheat_valid),
	.exe_done    (exe_done),
	.wr_error    (wr_error)
);

`default_nettype wire

// File: tb/tb_clk_gen.sv
//========================================
// 4 ns clock, rst_n low for two cycles
//========================================
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
	output logic clk_1x,
	output logic rst_n
);

	initial begin
		clk_1x = 1'b0;
	end

	always #2 clk_1x = ~clk_1x;

	// Release on the third rising edge
	initial begin
		rst_n <= 1'b0;
		repeat (2) @(posedge clk_1x);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: tb/tb_loader.sv
//========================================
// Host, AXI4-Lite slave model and cheat sink
// Stalls and data words come from LFSRs
// seeded with 62, outputs sampled at negedge
//========================================
`timescale 1ns/1ns
`default_nettype none

module tb_loader;

	localparam int wait_limit  = 400;
	localparam int drain_limit = 4000;

	logic                            clk_1x;
	logic                            rst_n;
	logic                            ioctl_download;
	logic [7:0]                      ioctl_index;
	logic [dl_pkg::ioctl_addr_w-1:0] ioctl_addr;
	logic [dl_pkg::ioctl_data_w-1:0] ioctl_dout;
	logic                            ioctl_wr;
	wire                             ioctl_wait;
	wire                             awvalid;
	wire  [mem_pkg::mem_addr_w-1:0]  awaddr;
	wire                             wvalid;
	wire  [mem_pkg::mem_data_w-1:0]  wdata;
	wire  [mem_pkg::strb_w-1:0]      wstrb;
	wire                             bready;
	wire                             cheat_valid;
	dl_pkg::cheat_code_t             cheat_code;
	wire                             cheat_clear;
	wire                             exe_done;
	wire                             wr_error;

	// Slave side inputs and their next values
	logic                       awready     = 1'b0;
	logic                       wready      = 1'b0;
	logic                       bvalid      = 1'b0;
	logic [mem_pkg::resp_w-1:0] bresp       = mem_pkg::resp_okay;
	logic                       cheat_ready = 1'b0;
	logic                       nxt_awready = 1'b0;
	logic                       nxt_wready  = 1'b0;
	logic                       nxt_bvalid  = 1'b0;
	logic [mem_pkg::resp_w-1:0] nxt_bresp   = mem_pkg::resp_okay;
	logic                       nxt_cheat_ready = 1'b0;

	//========================================
	// Scoreboard
	//========================================
	logic [mem_pkg::mem_addr_w-1:0] exp_addr_q [$];
	logic [mem_pkg::mem_data_w-1:0] exp_data_q [$];
	dl_pkg::cheat_code_t            exp_code_q [$];

	logic [15:0] lfsr_data    = 16'd62;
	logic [15:0] lfsr_stall   = 16'd62;
	int          axi_stall    = 0;
	int          cheat_stall  = 0;
	int          slverr_at    = -1;
	int          host_errors  = 0;
	int          timeouts     = 0;
	int          sink_errors  = 0;
	int          aw_count     = 0;
	int          w_count      = 0;
	int          b_count      = 0;
	int          exe_pulses   = 0;
	int          clear_pulses = 0;
	logic        wait_seen    = 1'b0;

	tb_clk_gen i_clk_gen (
		.clk_1x (clk_1x),
		.rst_n  (rst_n)
	);

	loader_top #(
		.RAM_FIFO_DEPTH  (4),
		.CODE_FIFO_DEPTH (2)
	) i_dut (
		.clk_1x         (clk_1x),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.ioctl_wait     (ioctl_wait),
		.awvalid        (awvalid),
		.awready        (awready),
		.awaddr         (awaddr),
		.wvalid         (wvalid),
		.wready         (wready),
		.wdata          (wdata),
		.wstrb          (wstrb),
		.bvalid         (bvalid),
		.bready         (bready),
		.bresp          (bresp),
		.cheat_valid    (cheat_valid),
		.cheat_code     (cheat_code),
		.cheat_ready    (cheat_ready),
		.cheat_clear    (cheat_clear),
		.exe_done       (exe_done),
		.wr_error       (wr_error)
	);

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// Level 0 never stalls, 1 stalls a quarter, 2 is ready one cycle in 8
	function automatic logic ready_from(input logic [2:0] r, input int level);
		if (level == 0)
			return 1'b1;
		if (level == 1)
			return r[1:0] != 2'b00;
		return r == 3'b000;
	endfunction

	task automatic stall_ready(input int level, output logic rdy);
		logic [2:0] r;
		r = '0;
		for (int i = 0; i < 3; i++) begin
			lfsr_stall = lfsr_next(lfsr_stall);
			r = {r[1:0], lfsr_stall[0]};
		end
		rdy = ready_from(r, level);
	endtask

	task automatic draw_word(output logic [15:0] w);
		w = '0;
		for (int i = 0; i < 16; i++) begin
			lfsr_data = lfsr_next(lfsr_data);
			w = {w[14:0], lfsr_data[0]};
		end
	endtask

	//========================================
	// Host side
	//========================================
	task automatic send_word(input logic [26:0] addr, input logic [15:0] data);
		int cycles;
		cycles = 0;
		@(negedge clk_1x);
		while (ioctl_wait && cycles < wait_limit) begin
			@(posedge clk_1x);
			ioctl_wr <= 1'b0;
			@(negedge clk_1x);
			cycles++;
		end
		if (ioctl_wait) begin
			timeouts++;
			$display("timeout at %0t: ioctl_wait stayed high", $time);
		end
		@(posedge clk_1x);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= addr;
		ioctl_dout <= data;
	endtask

	// Expects a one-cycle pulse in the second of three cycles
	task automatic check_pulse(input logic sel_exe);
		logic [2:0] seen;
		for (int i = 0; i < 3; i++) begin
			@(negedge clk_1x);
			seen[2-i] = sel_exe ? exe_done : cheat_clear;
		end
		assert (seen == 3'b010) else begin
			host_errors++;
			$display("mismatch at %0t: %s expected 010, got %b", $time,
				sel_exe ? "exe_done" : "cheat_clear", seen);
		end
	endtask

	task automatic mem_download(input logic [7:0] index, input int n_words,
			input logic [26:0] base);
		logic [15:0] lo;
		logic [15:0] hi;
		logic [26:0] a;
		@(posedge clk_1x);
		ioctl_index    <= index;
		ioctl_download <= 1'b1;
		for (int i = 0; i < n_words; i += 2) begin
			draw_word(lo);
			draw_word(hi);
			a = 27'(i * 2);
			exp_addr_q.push_back(a + base);
			exp_data_q.push_back({hi, lo});
			send_word(a, lo);
			send_word(a + 27'd2, hi);
		end
		@(posedge clk_1x);
		ioctl_wr       <= 1'b0;
		ioctl_download <= 1'b0;
		if (index == dl_pkg::idx_exe)
			check_pulse(1'b1);
	endtask

	// Each field is bottom word then top word
	task automatic code_download(input int n_codes);
		logic [15:0] w [8];
		@(posedge clk_1x);
		ioctl_index    <= dl_pkg::idx_code;
		ioctl_download <= 1'b1;
		check_pulse(1'b0);
		for (int c = 0; c < n_codes; c++) begin
			for (int k = 0; k < 8; k++)
				draw_word(w[k]);
			exp_code_q.push_back({w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]});
			for (int k = 0; k < 8; k++)
				send_word(27'(c * 16 + k * 2), w[k]);
		end
		@(posedge clk_1x);
		ioctl_wr       <= 1'b0;
		ioctl_download <= 1'b0;
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while ((exp_addr_q.size() != 0 || exp_data_q.size() != 0 ||
				exp_code_q.size() != 0 || b_count != aw_count) && cycles < drain_limit) begin
			@(negedge clk_1x);
			cycles++;
		end
		if (exp_addr_q.size() != 0 || exp_data_q.size() != 0 || exp_code_q.size() != 0 ||
				b_count != aw_count) begin
			timeouts++;
			$display("timeout at %0t: expected writes, codes or responses never arrived",
				$time);
		end
	endtask

	//========================================
	// AXI slave model and cheat sink
	//========================================
	always @(negedge clk_1x) begin
		if (rst_n) begin
			if (awvalid && awready) begin
				aw_count++;
				if (exp_addr_q.size() == 0) begin
					sink_errors++;
					$display("unexpected AXI write address %h at %0t", awaddr, $time);
				end else begin
					assert (awaddr == exp_addr_q[0]) else begin
						sink_errors++;
						$display("mismatch at %0t: awaddr expected %h, got %h", $time,
							exp_addr_q[0], awaddr);
					end
					void'(exp_addr_q.pop_front());
				end
			end
			if (wvalid && wready) begin
				w_count++;
				assert (wstrb == {mem_pkg::strb_w{1'b1}}) else begin
					sink_errors++;
					$display("mismatch at %0t: wstrb expected f, got %h", $time, wstrb);
				end
				if (exp_data_q.size() == 0) begin
					sink_errors++;
					$display("unexpected AXI write data %h at %0t", wdata, $time);
				end else begin
					assert (wdata == exp_data_q[0]) else begin
						sink_errors++;
						$display("mismatch at %0t: wdata expected %h, got %h", $time,
							exp_data_q[0], wdata);
					end
					void'(exp_data_q.pop_front());
				end
			end
			// Response only once both AW and W are in
			if (bvalid && bready) begin
				b_count++;
				nxt_bvalid = 1'b0;
			end else if (!bvalid && b_count < aw_count && b_count < w_count) begin
				stall_ready(axi_stall, nxt_bvalid);
				nxt_bresp = (b_count == slverr_at) ? 2'b10 : mem_pkg::resp_okay;
			end
			if (cheat_valid && cheat_ready) begin
				if (exp_code_q.size() == 0) begin
					sink_errors++;
					$display("unexpected cheat code %h at %0t", cheat_code, $time);
				end else begin
					assert (cheat_code == exp_code_q[0]) else begin
						sink_errors++;
						$display("mismatch at %0t: cheat_code expected %h, got %h", $time,
							exp_code_q[0], cheat_code);
					end
					void'(exp_code_q.pop_front());
				end
			end
			stall_ready(axi_stall, nxt_awready);
			stall_ready(axi_stall, nxt_wready);
			stall_ready(cheat_stall, nxt_cheat_ready);
			if (ioctl_wait)
				wait_seen = 1'b1;
			if (exe_done)
				exe_pulses++;
			if (cheat_clear)
				clear_pulses++;
		end
	end

	always @(posedge clk_1x) begin
		awready     <= nxt_awready;
		wready      <= nxt_wready;
		bvalid      <= nxt_bvalid;
		bresp       <= nxt_bresp;
		cheat_ready <= nxt_cheat_ready;
	end

	//========================================
	// Test sequence
	//========================================
	initial begin
		int cycles;
		int total;
		ioctl_download <= 1'b0;
		ioctl_index    <= 8'd0;
		ioctl_addr     <= '0;
		ioctl_dout     <= '0;
		ioctl_wr       <= 1'b0;
		cycles = 0;
		@(posedge clk_1x);
		while (!rst_n && cycles < 20) begin
			@(posedge clk_1x);
			cycles++;
		end
		if (!rst_n) begin
			timeouts++;
			$display("timeout at %0t: reset never released", $time);
		end

		// Quiet outputs before any stimulus
		repeat (3) begin
			@(negedge clk_1x);
			assert (!(awvalid || wvalid || bready || ioctl_wait || cheat_clear ||
					cheat_valid || exe_done || wr_error)) else begin
				host_errors++;
				$display("mismatch at %0t: control outputs expected 0, got %b", $time,
					{awvalid, wvalid, bready, ioctl_wait, cheat_clear, cheat_valid,
					exe_done, wr_error});
			end
		end

		axi_stall = 1;
		mem_download(dl_pkg::idx_bios, 16, dl_pkg::bios_base);
		wait_drained();
		mem_download(dl_pkg::idx_exe, 16, dl_pkg::exe_base);
		wait_drained();

		// Long stalls must fill the FIFO
		axi_stall = 2;
		mem_download(dl_pkg::idx_bios, 32, dl_pkg::bios_base);
		wait_drained();
		assert (wait_seen) else begin
			host_errors++;
			$display("ioctl_wait never rose under long AXI stalls");
		end

		axi_stall   = 0;
		cheat_stall = 2;
		code_download(2);
		wait_drained();

		assert (!wr_error) else begin
			host_errors++;
			$display("mismatch at %0t: wr_error expected 0, got %b", $time, wr_error);
		end
		slverr_at = b_count;
		mem_download(dl_pkg::idx_bios, 4, dl_pkg::bios_base);
		wait_drained();
		repeat (4) begin
			@(negedge clk_1x);
			assert (wr_error) else begin
				host_errors++;
				$display("mismatch at %0t: wr_error expected 1, got %b", $time, wr_error);
			end
		end
		assert (exe_pulses == 1 && clear_pulses == 1) else begin
			host_errors++;
			$display("mismatch at %0t: pulse counts expected 1 and 1, got %0d and %0d",
				$time, exe_pulses, clear_pulses);
		end

		total = host_errors + sink_errors + timeouts + i_dut.i_chk.chk_errors;
		$display("errors: %0d host, %0d sink, %0d timeout, %0d assertion", host_errors,
			sink_errors, timeouts, i_dut.i_chk.chk_errors);
		if (total == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
